// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [7:0]  imem_addr_t;
	typedef logic [7:0]  dmem_addr_t;
	typedef logic [4:0]  opcode_t;
	typedef logic [4:0]  alu_op_t;

	// Instruction field positions
	localparam int OP_HI     = 31;
	localparam int OP_LO     = 27;
	localparam int RD_HI     = 26;
	localparam int RD_LO     = 22;
	localparam int RS_HI     = 21;
	localparam int RS_LO     = 17;
	localparam int RT_HI     = 16;
	localparam int RT_LO     = 12;
	localparam int SHAMT_HI  = 11;
	localparam int SHAMT_LO  = 7;
	localparam int ALU_HI    = 6;
	localparam int ALU_LO    = 2;
	localparam int IMM_HI    = 16;
	localparam int IMM_LO    = 0;
	localparam int TARGET_HI = 26;
	localparam int TARGET_LO = 0;

	// Major opcodes
	localparam opcode_t OP_RTYPE = 5'd0;
	localparam opcode_t OP_J     = 5'd1;
	localparam opcode_t OP_BNE   = 5'd2;
	localparam opcode_t OP_ADDI  = 5'd5;
	localparam opcode_t OP_SW    = 5'd7;
	localparam opcode_t OP_LW    = 5'd8;

	// R-type ALU operations
	localparam alu_op_t ALU_ADD = 5'd0;
	localparam alu_op_t ALU_SUB = 5'd1;
	localparam alu_op_t ALU_AND = 5'd2;
	localparam alu_op_t ALU_OR  = 5'd3;
	localparam alu_op_t ALU_SLL = 5'd4;
	localparam alu_op_t ALU_SRA = 5'd5;

endpackage

`default_nettype wire

// ==== rtl/pipe_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One pipeline latch as seen by the stage after it
interface pipe_if;

	cpu_pkg::word_t pc;
	cpu_pkg::word_t ir;
	cpu_pkg::word_t a;
	cpu_pkg::word_t b;

	modport source (
		output pc, ir, a, b
	);

	modport sink (
		input pc, ir, a, b
	);

endinterface

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire cpu_pkg::word_t   operand_a,
	input  wire cpu_pkg::word_t   operand_b,
	input  wire cpu_pkg::alu_op_t op,
	input  wire [4:0]             shamt,
	output cpu_pkg::word_t        result,
	output logic                  not_equal,
	output logic                  less_than
);

	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD: result = operand_a + operand_b;
			cpu_pkg::ALU_SUB: result = operand_a - operand_b;
			cpu_pkg::ALU_AND: result = operand_a & operand_b;
			cpu_pkg::ALU_OR:  result = operand_a | operand_b;
			cpu_pkg::ALU_SLL: result = operand_a << shamt;
			// Arithmetic shift keeps the sign bit
			cpu_pkg::ALU_SRA: result = $signed(operand_a) >>> shamt;
			default:          result = '0;
		endcase
	end

	// Compare flags for branches
	assign not_equal = (operand_a != operand_b);
	assign less_than = ($signed(operand_a) < $signed(operand_b));

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
	parameter int IMEM_WORDS = 256
) (
	input  wire                  clock,
	input  wire                  reset,
	input  wire                  load_en,
	input  wire cpu_pkg::imem_addr_t load_addr,
	input  wire cpu_pkg::word_t  load_data,
	input  wire                  redirect,
	input  wire cpu_pkg::word_t  redirect_pc,
	output cpu_pkg::word_t       pc,
	pipe_if.source               fd
);

	localparam int AW = $clog2(IMEM_WORDS);

	cpu_pkg::word_t imem [IMEM_WORDS];
	cpu_pkg::word_t pc_next;
	cpu_pkg::word_t fetched;

	assign pc_next = pc + 32'd1;
	// Asynchronous read at the low counter bits
	assign fetched = imem[pc[AW-1:0]];

	// Program load only while the core is held in reset
	always_ff @(posedge clock) begin
		if (reset && load_en)
			imem[load_addr[AW-1:0]] <= load_data;
	end

	always_ff @(posedge clock) begin
		if (reset)
			pc <= '0;
		else if (redirect)
			pc <= redirect_pc;
		else
			pc <= pc_next;
	end

	//////////////////////////////////////////////////////////////////////
	// Fetch/decode latch
	always_ff @(posedge clock) begin
		fd.pc <= pc_next;
		if (reset)
			fd.ir <= '0;
		else
			fd.ir <= fetched;
	end

	assign fd.a = '0;
	assign fd.b = '0;

endmodule

`default_nettype wire

// ==== rtl/decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
	input  wire                     clock,
	input  wire                     reset,
	input  wire                     wb_en,
	input  wire cpu_pkg::reg_addr_t wb_reg,
	input  wire cpu_pkg::word_t     wb_data,
	pipe_if.sink                    fd,
	pipe_if.source                  dx
);

	cpu_pkg::word_t     regs [32];
	cpu_pkg::opcode_t   opcode;
	cpu_pkg::reg_addr_t read_a;
	cpu_pkg::reg_addr_t read_b;
	cpu_pkg::word_t     data_a;
	cpu_pkg::word_t     data_b;

	// r0 is hardwired and a same-cycle write is passed straight through
	function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_addr_t addr);
		if (addr == '0)
			return '0;
		if (wb_en && wb_reg == addr)
			return wb_data;
		return regs[addr];
	endfunction

	assign opcode = fd.ir[cpu_pkg::OP_HI:cpu_pkg::OP_LO];
	assign read_a = fd.ir[cpu_pkg::RS_HI:cpu_pkg::RS_LO];

	// Stores and branches carry their second source in the rd slot
	assign read_b = (opcode == cpu_pkg::OP_SW || opcode == cpu_pkg::OP_BNE)
		? fd.ir[cpu_pkg::RD_HI:cpu_pkg::RD_LO]
		: fd.ir[cpu_pkg::RT_HI:cpu_pkg::RT_LO];

	always_comb begin
		data_a = read_port(read_a);
		data_b = read_port(read_b);
	end

	//////////////////////////////////////////////////////////////////////
	// Register file
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wb_en) begin
			regs[wb_reg] <= wb_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Decode/execute latch
	always_ff @(posedge clock) begin
		dx.pc <= fd.pc;
		dx.a  <= data_a;
		dx.b  <= data_b;
		if (reset)
			dx.ir <= '0;
		else
			dx.ir <= fd.ir;
	end

endmodule

`default_nettype wire

// ==== rtl/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  wire            clock,
	input  wire            reset,
	output logic           redirect,
	output cpu_pkg::word_t redirect_pc,
	pipe_if.sink           dx,
	pipe_if.source         xm
);

	cpu_pkg::opcode_t opcode;
	cpu_pkg::alu_op_t alu_op;
	cpu_pkg::word_t   imm;
	cpu_pkg::word_t   operand_b;
	cpu_pkg::word_t   alu_result;
	logic             use_imm;
	logic             not_equal;

	assign opcode  = dx.ir[cpu_pkg::OP_HI:cpu_pkg::OP_LO];
	assign use_imm = (opcode == cpu_pkg::OP_ADDI) || (opcode == cpu_pkg::OP_LW) ||
		(opcode == cpu_pkg::OP_SW);
	assign imm = {{15{dx.ir[cpu_pkg::IMM_HI]}}, dx.ir[cpu_pkg::IMM_HI:cpu_pkg::IMM_LO]};

	// Address arithmetic is always an add
	assign alu_op    = use_imm ? cpu_pkg::ALU_ADD : dx.ir[cpu_pkg::ALU_HI:cpu_pkg::ALU_LO];
	assign operand_b = use_imm ? imm : dx.b;

	alu alu0 (
		.operand_a (dx.a),
		.operand_b (operand_b),
		.op        (alu_op),
		.shamt     (dx.ir[cpu_pkg::SHAMT_HI:cpu_pkg::SHAMT_LO]),
		.result    (alu_result),
		.not_equal (not_equal),
		.less_than ()
	);

	//////////////////////////////////////////////////////////////////////
	// Redirect. dx.pc already holds the branch pc plus one
	assign redirect = (opcode == cpu_pkg::OP_J) || (opcode == cpu_pkg::OP_BNE && not_equal);
	assign redirect_pc = (opcode == cpu_pkg::OP_J)
		? {5'b0, dx.ir[cpu_pkg::TARGET_HI:cpu_pkg::TARGET_LO]}
		: dx.pc + imm;

	// Execute/memory latch
	always_ff @(posedge clock) begin
		xm.pc <= dx.pc;
		xm.a  <= alu_result;
		xm.b  <= dx.b;
		if (reset)
			xm.ir <= '0;
		else
			xm.ir <= dx.ir;
	end

endmodule

`default_nettype wire

// ==== rtl/memory_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_unit #(
	parameter int DMEM_WORDS = 256
) (
	input  wire                  clock,
	input  wire                  reset,
	output logic                 wb_en,
	output cpu_pkg::reg_addr_t   wb_reg,
	output cpu_pkg::word_t       wb_data,
	output logic                 dmem_wren,
	output cpu_pkg::dmem_addr_t  dmem_addr,
	output cpu_pkg::word_t       dmem_data,
	pipe_if.sink                 xm
);

	localparam int AW = $clog2(DMEM_WORDS);

	cpu_pkg::word_t     dmem [DMEM_WORDS];
	cpu_pkg::opcode_t   opcode;
	cpu_pkg::reg_addr_t rd;
	cpu_pkg::word_t     load_word;
	cpu_pkg::word_t     mw_result;
	cpu_pkg::word_t     mw_load;
	logic               mw_is_lw;
	logic               writes_reg;

	assign opcode    = xm.ir[cpu_pkg::OP_HI:cpu_pkg::OP_LO];
	assign rd        = xm.ir[cpu_pkg::RD_HI:cpu_pkg::RD_LO];
	assign dmem_wren = (opcode == cpu_pkg::OP_SW);
	assign dmem_addr = xm.a[7:0];
	assign dmem_data = xm.b;
	assign load_word = dmem[dmem_addr[AW-1:0]];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= '0;
		end else if (dmem_wren) begin
			dmem[dmem_addr[AW-1:0]] <= dmem_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Memory/writeback latch
	// No writeback for r0
	assign writes_reg = (opcode == cpu_pkg::OP_RTYPE || opcode == cpu_pkg::OP_ADDI ||
		opcode == cpu_pkg::OP_LW) && (rd != '0);

	always_ff @(posedge clock) begin
		mw_result <= xm.a;
		mw_load   <= load_word;
		wb_reg    <= rd;
		if (reset) begin
			wb_en    <= 1'b0;
			mw_is_lw <= 1'b0;
		end else begin
			wb_en    <= writes_reg;
			mw_is_lw <= (opcode == cpu_pkg::OP_LW);
		end
	end

	assign wb_data = mw_is_lw ? mw_load : mw_result;

endmodule

`default_nettype wire

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input  wire                      clock,
	input  wire                      reset,
	input  wire                      imem_load_en,
	input  wire cpu_pkg::imem_addr_t imem_load_addr,
	input  wire cpu_pkg::word_t      imem_load_data,
	output wire cpu_pkg::word_t      pc_out,
	output wire                      wb_en,
	output wire cpu_pkg::reg_addr_t  wb_reg,
	output wire cpu_pkg::word_t      wb_data,
	output wire                      dmem_wren,
	output wire cpu_pkg::dmem_addr_t dmem_addr,
	output wire cpu_pkg::word_t      dmem_data
);

	wire            redirect;
	cpu_pkg::word_t redirect_pc;

	// Stage latches
	pipe_if fd_bus ();
	pipe_if dx_bus ();
	pipe_if xm_bus ();

	fetch_unit #(.IMEM_WORDS(IMEM_WORDS)) fetch0 (
		.clock       (clock),
		.reset       (reset),
		.load_en     (imem_load_en),
		.load_addr   (imem_load_addr),
		.load_data   (imem_load_data),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.pc          (pc_out),
		.fd          (fd_bus.source)
	);

	decode_unit decode0 (
		.clock   (clock),
		.reset   (reset),
		.wb_en   (wb_en),
		.wb_reg  (wb_reg),
		.wb_data (wb_data),
		.fd      (fd_bus.sink),
		.dx      (dx_bus.source)
	);

	execute_unit execute0 (
		.clock       (clock),
		.reset       (reset),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.dx          (dx_bus.sink),
		.xm          (xm_bus.source)
	);

	memory_unit #(.DMEM_WORDS(DMEM_WORDS)) memory0 (
		.clock     (clock),
		.reset     (reset),
		.wb_en     (wb_en),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data),
		.dmem_wren (dmem_wren),
		.dmem_addr (dmem_addr),
		.dmem_data (dmem_data),
		.xm        (xm_bus.sink)
	);

endmodule

`default_nettype wire

// ==== tb/cpu_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_sva (
	input wire                     clock,
	input wire                     reset,
	input wire                     wb_en,
	input wire cpu_pkg::reg_addr_t wb_reg,
	input wire                     dmem_wren,
	input wire cpu_pkg::word_t     pc_out,
	input wire                     redirect,
	input wire cpu_pkg::word_t     redirect_pc
);

	// r0 is never a writeback target
	wb_not_r0: assert property (@(posedge clock) disable iff (reset)
		wb_en |-> wb_reg != '0)
		else $error("writeback raised for r0");

	// One edge of sync reset clears the pipeline
	quiet_in_reset: assert property (@(posedge clock)
		reset && $past(reset) |-> !wb_en && !dmem_wren)
		else $error("writeback or store while reset is held");

	pc_steps: assert property (@(posedge clock) disable iff (reset)
		!$past(reset) |->
		pc_out == ($past(redirect) ? $past(redirect_pc) : $past(pc_out) + 32'd1))
		else $error("program counter neither stepped by one nor took a redirect");

endmodule

bind cpu_top cpu_sva sva0 (
	.clock       (clock),
	.reset       (reset),
	.wb_en       (wb_en),
	.wb_reg      (wb_reg),
	.dmem_wren   (dmem_wren),
	.pc_out      (pc_out),
	.redirect    (redirect),
	.redirect_pc (redirect_pc)
);

`default_nettype wire

// ==== tb/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

	// Five programs with loading take about 210 cycles
	localparam int TIMEOUT_CYCLES = 400;

	logic                clock = 1'b0;
	logic                reset = 1'b1;
	logic                imem_load_en = 1'b0;
	cpu_pkg::imem_addr_t imem_load_addr = '0;
	cpu_pkg::word_t      imem_load_data = '0;
	cpu_pkg::word_t      pc_out;
	logic                wb_en;
	cpu_pkg::reg_addr_t  wb_reg;
	cpu_pkg::word_t      wb_data;
	logic                dmem_wren;
	cpu_pkg::dmem_addr_t dmem_addr;
	cpu_pkg::word_t      dmem_data;

	int          cycle_count = 0;
	logic [15:0] lfsr = 16'd20116;

	// Program under test and the results it should produce
	cpu_pkg::word_t      prog [$];
	cpu_pkg::word_t      mregs [32];
	cpu_pkg::word_t      mmem [256];
	cpu_pkg::word_t      exp_pc [$];
	cpu_pkg::reg_addr_t  exp_reg [$];
	cpu_pkg::word_t      exp_wb [$];
	cpu_pkg::dmem_addr_t exp_addr [$];
	cpu_pkg::word_t      exp_store [$];

	cpu_top dut0 (
		.clock          (clock),
		.reset          (reset),
		.imem_load_en   (imem_load_en),
		.imem_load_addr (imem_load_addr),
		.imem_load_data (imem_load_data),
		.pc_out         (pc_out),
		.wb_en          (wb_en),
		.wb_reg         (wb_reg),
		.wb_data        (wb_data),
		.dmem_wren      (dmem_wren),
		.dmem_addr      (dmem_addr),
		.dmem_data      (dmem_data)
	);

	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display(">>> FAIL");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic cpu_pkg::word_t random_bits(input int n);
		cpu_pkg::word_t v;
		logic           fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic cpu_pkg::word_t encode_rtype(input cpu_pkg::alu_op_t fn,
		input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rs,
		input cpu_pkg::reg_addr_t rt, input logic [4:0] sh);
		return {cpu_pkg::OP_RTYPE, rd, rs, rt, sh, fn, 2'b00};
	endfunction

	function automatic cpu_pkg::word_t encode_imm(input cpu_pkg::opcode_t op,
		input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rs, input cpu_pkg::word_t imm);
		return {op, rd, rs, imm[16:0]};
	endfunction

	function automatic cpu_pkg::word_t encode_jump(input cpu_pkg::word_t target);
		return {cpu_pkg::OP_J, target[26:0]};
	endfunction

	task automatic emit(input cpu_pkg::word_t w);
		prog.push_back(w);
	endtask

	task automatic add_nops(input int n);
		repeat (n) emit('0);
	endtask

	task automatic emit_load_imm(input cpu_pkg::reg_addr_t rd, input cpu_pkg::word_t value);
		emit(encode_imm(cpu_pkg::OP_ADDI, rd, 5'd0, value));
	endtask

	//////////////////////////////////////////////////////////////////////
	// ISA model with two delay slots after a taken bne or j

	function automatic cpu_pkg::word_t expected_alu(input cpu_pkg::alu_op_t fn,
		input cpu_pkg::word_t a, input cpu_pkg::word_t b, input logic [4:0] sh);
		case (fn)
			cpu_pkg::ALU_ADD: return a + b;
			cpu_pkg::ALU_SUB: return a - b;
			cpu_pkg::ALU_AND: return a & b;
			cpu_pkg::ALU_OR:  return a | b;
			cpu_pkg::ALU_SLL: return a << sh;
			cpu_pkg::ALU_SRA: return $signed(a) >>> sh;
			default:          return '0;
		endcase
	endfunction

	task automatic write_reg(input cpu_pkg::reg_addr_t r, input cpu_pkg::word_t v);
		if (r != '0) begin
			mregs[r] = v;
			exp_reg.push_back(r);
			exp_wb.push_back(v);
		end
	endtask

	task automatic predict_results(input int term);
		int             pc;
		int             left;
		int             steps;
		logic           pend;
		logic           taken;
		cpu_pkg::word_t ins;
		cpu_pkg::word_t a;
		cpu_pkg::word_t imm;
		cpu_pkg::word_t ea;
		cpu_pkg::word_t tgt;
		pc = 0;
		left = 0;
		steps = 0;
		pend = 1'b0;
		tgt = '0;
		for (int r = 0; r < 32; r++)
			mregs[r] = '0;
		for (int m = 0; m < 256; m++)
			mmem[m] = '0;
		exp_pc.delete();
		exp_reg.delete();
		exp_wb.delete();
		exp_addr.delete();
		exp_store.delete();
		while (pc != term && steps < 500) begin
			// One fetch per cycle, delay slots included
			exp_pc.push_back(pc);
			ins = prog[pc];
			a = mregs[ins[21:17]];
			imm = {{15{ins[16]}}, ins[16:0]};
			ea = a + imm;
			taken = 1'b0;
			case (ins[31:27])
				cpu_pkg::OP_RTYPE: write_reg(ins[26:22],
					expected_alu(ins[6:2], a, mregs[ins[16:12]], ins[11:7]));
				cpu_pkg::OP_ADDI: write_reg(ins[26:22], ea);
				cpu_pkg::OP_LW:   write_reg(ins[26:22], mmem[ea[7:0]]);
				cpu_pkg::OP_SW: begin
					mmem[ea[7:0]] = mregs[ins[26:22]];
					exp_addr.push_back(ea[7:0]);
					exp_store.push_back(mregs[ins[26:22]]);
				end
				cpu_pkg::OP_BNE: begin
					taken = (a != mregs[ins[26:22]]);
					tgt = pc + 1 + imm;
				end
				cpu_pkg::OP_J: begin
					taken = 1'b1;
					tgt = {5'b0, ins[26:0]};
				end
				default: ;
			endcase
			if (taken) begin
				pend = 1'b1;
				left = 2;
				pc = pc + 1;
			end else if (pend && left == 1) begin
				pend = 1'b0;
				pc = int'(tgt);
			end else begin
				left = left - 1;
				pc = pc + 1;
			end
			steps++;
		end
		exp_pc.push_back(term);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checking

	task automatic fail_now(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1, "check failed");
	endtask

	task automatic check_word(input string name, input cpu_pkg::word_t expected,
		input cpu_pkg::word_t actual);
		if (expected !== actual)
			fail_now($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic check_reg(input string name, input cpu_pkg::reg_addr_t expected,
		input cpu_pkg::reg_addr_t actual);
		if (expected !== actual)
			fail_now($sformatf("ERROR %s: expected r%0d, actual r%0d", name, expected, actual));
	endtask

	task automatic check_addr(input string name, input cpu_pkg::dmem_addr_t expected,
		input cpu_pkg::dmem_addr_t actual);
		if (expected !== actual)
			fail_now($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
	endtask

	task automatic check_cycle(input string name);
		if (wb_en) begin
			if (exp_reg.size() == 0) begin
				fail_now($sformatf("%s: unexpected writeback to r%0d", name, wb_reg));
			end else begin
				check_reg(name, exp_reg.pop_front(), wb_reg);
				check_word(name, exp_wb.pop_front(), wb_data);
			end
		end
		if (dmem_wren) begin
			if (exp_addr.size() == 0) begin
				fail_now($sformatf("%s: unexpected store to address %h", name, dmem_addr));
			end else begin
				check_addr(name, exp_addr.pop_front(), dmem_addr);
				check_word(name, exp_store.pop_front(), dmem_data);
			end
		end
	endtask

	// One word per cycle while reset is held, at least 8 cycles
	task automatic load_program();
		for (int i = 0; i < prog.size() || i < 8; i++) begin
			@(posedge clock);
			reset <= 1'b1;
			imem_load_en <= (i < prog.size());
			imem_load_addr <= i[7:0];
			imem_load_data <= (i < prog.size()) ? prog[i] : '0;
		end
		@(posedge clock);
		imem_load_en <= 1'b0;
		reset <= 1'b0;
	endtask

	// Ends the program with a jump to itself, then runs until it is fetched
	task automatic run_program(input string name);
		int term;
		term = prog.size();
		emit(encode_jump(term));
		add_nops(2);
		predict_results(term);
		load_program();
		while (pc_out != term) begin
			@(negedge clock);
			if (exp_pc.size() == 0)
				fail_now($sformatf("%s: program counter left the expected path", name));
			else
				check_word(name, exp_pc.pop_front(), pc_out);
			check_cycle(name);
		end
		// Drain the four stages behind the last fetch
		repeat (5) begin
			@(negedge clock);
			check_cycle(name);
		end
		if (exp_reg.size() != 0 || exp_addr.size() != 0)
			fail_now($sformatf("%s: %0d writebacks and %0d stores never appeared",
				name, exp_reg.size(), exp_addr.size()));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_alu();
		cpu_pkg::alu_op_t ops [6];
		ops = '{cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB, cpu_pkg::ALU_AND,
			cpu_pkg::ALU_OR, cpu_pkg::ALU_SLL, cpu_pkg::ALU_SRA};
		prog.delete();
		emit_load_imm(5'd1, random_bits(17));
		emit_load_imm(5'd2, random_bits(17));
		add_nops(2);
		// Shift amounts from 1 to 16
		for (int i = 0; i < 6; i++) begin
			emit(encode_rtype(ops[i], 5'(i + 3), 5'd1, 5'd2, 5'(random_bits(4)) + 5'd1));
			add_nops(3);
		end
		run_program("alu_ops");
	endtask

	task automatic test_write_through();
		prog.delete();
		emit_load_imm(5'd1, random_bits(17));
		add_nops(2);
		emit(encode_rtype(cpu_pkg::ALU_ADD, 5'd2, 5'd1, 5'd1, 5'd0));
		add_nops(2);
		emit(encode_imm(cpu_pkg::OP_ADDI, 5'd3, 5'd2, random_bits(17)));
		add_nops(2);
		emit(encode_rtype(cpu_pkg::ALU_SUB, 5'd4, 5'd3, 5'd1, 5'd0));
		run_program("write_through");
	endtask

	task automatic test_load_store();
		int offsets [3];
		offsets = '{0, 1, -3};
		prog.delete();
		for (int r = 1; r <= 3; r++)
			emit_load_imm(5'(r), random_bits(17));
		emit_load_imm(5'd5, 32'd8);
		add_nops(2);
		for (int i = 0; i < 3; i++)
			emit(encode_imm(cpu_pkg::OP_SW, 5'(i + 1), 5'd5, offsets[i]));
		for (int i = 0; i < 3; i++)
			emit(encode_imm(cpu_pkg::OP_LW, 5'(i + 6), 5'd5, offsets[i]));
		run_program("load_store");
	endtask

	task automatic test_branch();
		prog.delete();
		emit_load_imm(5'd1, 32'd5);
		emit_load_imm(5'd2, 32'd7);
		emit_load_imm(5'd3, 32'd5);
		add_nops(2);
		// Taken, target 5 + 1 + 4
		emit(encode_imm(cpu_pkg::OP_BNE, 5'd2, 5'd1, 32'd4));
		emit_load_imm(5'd4, 32'd1);
		emit_load_imm(5'd5, 32'd2);
		emit_load_imm(5'd6, 32'd3);
		emit_load_imm(5'd7, 32'd4);
		// Equal operands fall through
		emit(encode_imm(cpu_pkg::OP_BNE, 5'd3, 5'd1, 32'd5));
		emit_load_imm(5'd8, 32'd6);
		emit_load_imm(5'd9, 32'd7);
		emit_load_imm(5'd10, 32'd8);
		run_program("branch");
	endtask

	task automatic test_jump_r0();
		prog.delete();
		emit_load_imm(5'd0, 32'd123);
		emit_load_imm(5'd1, 32'd9);
		emit(encode_jump(32'd6));
		emit_load_imm(5'd2, 32'd11);
		emit_load_imm(5'd3, 32'd12);
		emit_load_imm(5'd4, 32'd13);
		emit(encode_rtype(cpu_pkg::ALU_ADD, 5'd5, 5'd0, 5'd1, 5'd0));
		emit(encode_rtype(cpu_pkg::ALU_OR, 5'd6, 5'd0, 5'd0, 5'd0));
		run_program("jump_r0");
	endtask

	initial begin
		test_alu();
		test_write_through();
		test_load_store();
		test_branch();
		test_jump_r0();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/cpu_pkg.sv
rtl/pipe_if.sv
rtl/alu.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/memory_unit.sv
rtl/cpu_top.sv
tb/cpu_sva.sv
tb/tb_cpu.sv

// ==== Makefile ====
# Verilator simulation of the pipelined CPU

VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
